/* list.f */
+incdir+.
csr_addr_pkg.sv
csr_priv_pkg.sv
csr_write_buffer.sv
csr_trap_ctrl.sv
csr_irq_ctrl.sv
csr_counters.sv
csr_read_mux.sv
csr_atomic_check.sv
csr_file_top.sv
tb_csr_file.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_csr_file
FILELIST   := list.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* tb_csr_file.sv */
//**************************************************************************
// directed tests of the CSR file; inputs change 1 ns after the rising edge
//**************************************************************************
`timescale 1ns/1ps
`include "csr_cfg.svh"

module tb_csr_file;

  localparam int CLK_PERIOD = 8;
  // all six tests together take well under 200 cycles
  localparam int TIMEOUT_CYCLES = 2000;
  localparam logic [`CSR_XLEN-1:0] START_PC = 32'h0000_1003;
  localparam logic [`CSR_XLEN-1:0] HART_ID  = 32'h0000_0005;
  // mstatus fields in the 32-bit word
  localparam logic [`CSR_XLEN-1:0] ST_MIE   = 32'h0000_0008;
  localparam logic [`CSR_XLEN-1:0] ST_MPIE  = 32'h0000_0080;
  localparam logic [`CSR_XLEN-1:0] ST_MPP_M = 32'h0000_1800;

  logic                      clk;
  logic                      reset;
  logic                      flush_i;
  logic                      wr_en_i;
  logic [`CSR_ADDR_W-1:0]    wr_addr_i;
  logic [`CSR_XLEN-1:0]      wr_data_i;
  logic                      commit_i;
  logic                      rd_en_i;
  logic [`CSR_ADDR_W-1:0]    rd_addr_i;
  logic [`CSR_XLEN-1:0]      rd_data_o;
  logic [`CSR_COMMIT_W-1:0]  commit_count_i;
  logic                      exception_i;
  logic [`CSR_XLEN-1:0]      exception_pc_i;
  csr_priv_pkg::trap_cause_e exception_cause_i;
  logic                      mret_i;
  logic                      ext_irq_i;
  logic                      timer_irq_i;
  logic                      soft_irq_i;
  logic [`CSR_XLEN-1:0]      hart_id_i;
  logic [`CSR_XLEN-1:0]      start_pc_i;
  logic                      atomic_vio_o;
  logic                      irq_pending_o;
  logic [`CSR_XLEN-1:0]      epc_o;
  logic [`CSR_XLEN-1:0]      evec_o;
  csr_priv_pkg::priv_lvl_e   priv_lvl_o;
  integer                    seed = 33252;

  csr_file_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Simulation finished: FAIL");
    $fatal(1, "watchdog expired");
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic check_equal(input logic [`CSR_XLEN-1:0] actual,
                             input logic [`CSR_XLEN-1:0] expected, input string what);
    if (actual !== expected) begin
      $display("FAIL at time %0t: %s, got 0x%h, expected 0x%h", $time, what, actual, expected);
      $display("Simulation finished: FAIL");
      $fatal(1, "mismatch on %s", what);
    end
  endtask

  // combinational read, sampled 1 ns after the address is set
  task automatic read_csr(input logic [`CSR_ADDR_W-1:0] addr,
                          output logic [`CSR_XLEN-1:0] data);
    rd_addr_i = addr;
    #1;
    data = rd_data_o;
  endtask

  task automatic expect_csr(input logic [`CSR_ADDR_W-1:0] addr,
                            input logic [`CSR_XLEN-1:0] expected, input string what);
    logic [`CSR_XLEN-1:0] value;
    read_csr(addr, value);
    check_equal(value, expected, what);
  endtask

  task automatic write_csr(input logic [`CSR_ADDR_W-1:0] addr,
                           input logic [`CSR_XLEN-1:0] data);
    wr_en_i   = 1'b1;
    wr_addr_i = addr;
    wr_data_i = data;
    next_cycle();
    wr_en_i = 1'b0;
  endtask

  task automatic pulse_commit();
    commit_i = 1'b1;
    next_cycle();
    commit_i = 1'b0;
  endtask

  task automatic pulse_flush();
    flush_i = 1'b1;
    next_cycle();
    flush_i = 1'b0;
  endtask

  // the buffer keeps the write after commit, so drop it afterwards
  task automatic commit_write(input logic [`CSR_ADDR_W-1:0] addr,
                              input logic [`CSR_XLEN-1:0] data);
    write_csr(addr, data);
    pulse_commit();
    pulse_flush();
  endtask

  task automatic reset_values();
    check_equal({30'd0, priv_lvl_o}, 32'd3, "privilege after reset");
    check_equal({31'd0, atomic_vio_o}, 32'd0, "atomic_vio_o after reset");
    check_equal({31'd0, irq_pending_o}, 32'd0, "irq_pending_o after reset");
    check_equal(evec_o, START_PC & 32'hFFFF_FFFC, "evec_o after reset");
    expect_csr(csr_addr_pkg::CSR_MTVEC, START_PC, "mtvec after reset");
    expect_csr(csr_addr_pkg::CSR_MSTATUS, 32'd0, "mstatus after reset");
    expect_csr(csr_addr_pkg::CSR_MSCRATCH, 32'd0, "mscratch after reset");
    expect_csr(csr_addr_pkg::CSR_MHARTID, HART_ID, "mhartid");
  endtask

  task automatic write_until_commit();
    logic [`CSR_XLEN-1:0] first;
    logic [`CSR_XLEN-1:0] second;
    first  = $random(seed);
    second = ~first;
    write_csr(csr_addr_pkg::CSR_MSCRATCH, first);
    expect_csr(csr_addr_pkg::CSR_MSCRATCH, 32'd0, "mscratch before commit");
    pulse_commit();
    expect_csr(csr_addr_pkg::CSR_MSCRATCH, first, "mscratch after commit");
    pulse_flush();
    write_csr(csr_addr_pkg::CSR_MSCRATCH, second);
    pulse_flush();
    pulse_commit();
    expect_csr(csr_addr_pkg::CSR_MSCRATCH, first, "mscratch after flushed write");
  endtask

  task automatic trap_entry_and_mret();
    logic [`CSR_XLEN-1:0] pc;
    pc = $random(seed);
    commit_write(csr_addr_pkg::CSR_MSTATUS, ST_MIE);
    exception_i       = 1'b1;
    exception_pc_i    = pc;
    exception_cause_i = csr_priv_pkg::CAUSE_ECALL_M;
    next_cycle();
    exception_i = 1'b0;
    check_equal(epc_o, pc & 32'hFFFF_FFFE, "epc_o after trap");
    expect_csr(csr_addr_pkg::CSR_MEPC, pc & 32'hFFFF_FFFE, "mepc after trap");
    expect_csr(csr_addr_pkg::CSR_MCAUSE, 32'd11, "mcause after trap");
    expect_csr(csr_addr_pkg::CSR_MSTATUS, ST_MPIE | ST_MPP_M, "mstatus after trap");
    mret_i = 1'b1;
    next_cycle();
    mret_i = 1'b0;
    expect_csr(csr_addr_pkg::CSR_MSTATUS, ST_MIE | ST_MPIE, "mstatus after mret");
    check_equal({30'd0, priv_lvl_o}, 32'd3, "privilege after mret to machine");
    // mpp = user in the written word
    commit_write(csr_addr_pkg::CSR_MSTATUS, ST_MIE);
    mret_i = 1'b1;
    next_cycle();
    mret_i = 1'b0;
    check_equal({30'd0, priv_lvl_o}, 32'd0, "privilege after mret to user");
    expect_csr(csr_addr_pkg::CSR_MSTATUS, ST_MPIE, "mstatus after mret to user");
  endtask

  task automatic counter_growth();
    logic [`CSR_XLEN-1:0] first;
    logic [`CSR_XLEN-1:0] second;
    logic [`CSR_XLEN-1:0] sum;
    logic [`CSR_XLEN-1:0] rnd;
    read_csr(csr_addr_pkg::CSR_MCYCLE, first);
    repeat (7) next_cycle();
    read_csr(csr_addr_pkg::CSR_MCYCLE, second);
    check_equal(second - first, 32'd7, "mcycle over 7 cycles");
    sum = '0;
    read_csr(csr_addr_pkg::CSR_MINSTRET, first);
    for (int i = 0; i < 6; i++) begin
      next_cycle();
      rnd            = $random(seed);
      commit_count_i = rnd[2:0];
      sum            = sum + {29'd0, rnd[2:0]};
    end
    next_cycle();
    commit_count_i = '0;
    read_csr(csr_addr_pkg::CSR_INSTRET, second);
    check_equal(second - first, sum, "instret growth over commit counts");
    rnd = $random(seed);
    write_csr(csr_addr_pkg::CSR_MCYCLE, rnd);
    pulse_commit();
    expect_csr(csr_addr_pkg::CSR_MCYCLE, rnd, "mcycle right after write");
    repeat (5) next_cycle();
    expect_csr(csr_addr_pkg::CSR_CYCLE, rnd + 32'd5, "cycle 5 cycles after write");
    pulse_flush();
  endtask

  task automatic interrupt_masking();
    commit_write(csr_addr_pkg::CSR_MIE, 32'h0000_0080);
    timer_irq_i = 1'b1;
    expect_csr(csr_addr_pkg::CSR_MIP, 32'h0000_0080, "mip with timer line");
    check_equal({31'd0, irq_pending_o}, 32'd1, "pending in user mode");
    // trap to machine mode clears mstatus.mie
    exception_i       = 1'b1;
    exception_pc_i    = 32'h0000_0100;
    exception_cause_i = csr_priv_pkg::CAUSE_ILLEGAL_INSTR;
    next_cycle();
    exception_i = 1'b0;
    check_equal({31'd0, irq_pending_o}, 32'd0, "pending in machine mode, mie clear");
    mret_i = 1'b1;
    next_cycle();
    mret_i = 1'b0;
    check_equal({30'd0, priv_lvl_o}, 32'd0, "privilege back in user mode");
    check_equal({31'd0, irq_pending_o}, 32'd1, "pending again in user mode");
    timer_irq_i = 1'b0;
    ext_irq_i   = 1'b1;
    #1;
    check_equal({31'd0, irq_pending_o}, 32'd0, "pending from a line not enabled");
  endtask

  task automatic read_change_flag();
    logic [`CSR_XLEN-1:0] value;
    rd_en_i   = 1'b1;
    rd_addr_i = csr_addr_pkg::CSR_MIP;
    next_cycle();
    rd_en_i = 1'b0;
    check_equal({31'd0, atomic_vio_o}, 32'd0, "violation right after mip read");
    soft_irq_i = 1'b1;
    #1;
    check_equal({31'd0, atomic_vio_o}, 32'd1, "violation after soft line change");
    pulse_flush();
    check_equal({31'd0, atomic_vio_o}, 32'd0, "violation after flush");
    soft_irq_i = 1'b0;
    value      = $random(seed);
    write_csr(csr_addr_pkg::CSR_MSCRATCH, value);
    rd_en_i   = 1'b1;
    rd_addr_i = csr_addr_pkg::CSR_MSCRATCH;
    next_cycle();
    rd_en_i = 1'b0;
    check_equal({31'd0, atomic_vio_o}, 32'd0, "violation after mscratch read");
    pulse_commit();
    check_equal({31'd0, atomic_vio_o}, 32'd0, "violation after commit");
    expect_csr(csr_addr_pkg::CSR_MSCRATCH, value, "mscratch after commit");
    pulse_flush();
  endtask

  initial begin
    reset             = 1'b1;
    flush_i           = 1'b0;
    wr_en_i           = 1'b0;
    wr_addr_i         = '0;
    wr_data_i         = '0;
    commit_i          = 1'b0;
    rd_en_i           = 1'b0;
    rd_addr_i         = '0;
    commit_count_i    = '0;
    exception_i       = 1'b0;
    exception_pc_i    = '0;
    exception_cause_i = csr_priv_pkg::CAUSE_MISALIGNED_FETCH;
    mret_i            = 1'b0;
    ext_irq_i         = 1'b0;
    timer_irq_i       = 1'b0;
    soft_irq_i        = 1'b0;
    hart_id_i         = HART_ID;
    start_pc_i        = START_PC;
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    reset_values();
    write_until_commit();
    trap_entry_and_mret();
    counter_growth();
    interrupt_masking();
    read_change_flag();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

/* csr_file_top.sv */
//**************************************************************************
// machine-mode CSR file, RV32 with machine and user privilege
//**************************************************************************
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_file_top (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      flush_i,
  input  logic                      wr_en_i,
  input  logic [`CSR_ADDR_W-1:0]    wr_addr_i,
  input  logic [`CSR_XLEN-1:0]      wr_data_i,
  input  logic                      commit_i,
  input  logic                      rd_en_i,
  input  logic [`CSR_ADDR_W-1:0]    rd_addr_i,
  output logic [`CSR_XLEN-1:0]      rd_data_o,
  input  logic [`CSR_COMMIT_W-1:0]  commit_count_i,
  input  logic                      exception_i,
  input  logic [`CSR_XLEN-1:0]      exception_pc_i,
  input  csr_priv_pkg::trap_cause_e exception_cause_i,
  input  logic                      mret_i,
  input  logic                      ext_irq_i,
  input  logic                      timer_irq_i,
  input  logic                      soft_irq_i,
  input  logic [`CSR_XLEN-1:0]      hart_id_i,
  input  logic [`CSR_XLEN-1:0]      start_pc_i,
  output logic                      atomic_vio_o,
  output logic                      irq_pending_o,
  output logic [`CSR_XLEN-1:0]      epc_o,
  output logic [`CSR_XLEN-1:0]      evec_o,
  output csr_priv_pkg::priv_lvl_e   priv_lvl_o
);

  logic                   cmt_we;
  logic [`CSR_ADDR_W-1:0] cmt_addr;
  logic [`CSR_XLEN-1:0]   cmt_data;
  csr_priv_pkg::mstatus_t mstatus;
  logic [`CSR_XLEN-1:0]   mcause;
  logic [`CSR_XLEN-1:0]   mtvec;
  logic [`CSR_XLEN-1:0]   mscratch;
  logic [`CSR_XLEN-1:0]   mie;
  logic [`CSR_XLEN-1:0]   mip;
  logic [`CSR_XLEN-1:0]   mcycle;
  logic [`CSR_XLEN-1:0]   minstret;
  logic [`CSR_ADDR_W-1:0] chk_addr;
  logic [`CSR_XLEN-1:0]   chk_data;

  csr_write_buffer wr_buf (
    .clk, .reset, .flush_i, .wr_en_i, .wr_addr_i, .wr_data_i, .commit_i,
    .cmt_we_o(cmt_we), .cmt_addr_o(cmt_addr), .cmt_data_o(cmt_data)
  );

  csr_trap_ctrl trap (
    .clk, .reset, .cmt_we_i(cmt_we), .cmt_addr_i(cmt_addr), .cmt_data_i(cmt_data),
    .exception_i, .exception_pc_i, .exception_cause_i, .mret_i, .start_pc_i,
    .priv_lvl_o, .mstatus_o(mstatus), .mepc_o(epc_o), .mcause_o(mcause),
    .mtvec_o(mtvec), .mscratch_o(mscratch), .evec_o
  );

  csr_irq_ctrl irq (
    .clk, .reset, .cmt_we_i(cmt_we), .cmt_addr_i(cmt_addr), .cmt_data_i(cmt_data),
    .ext_irq_i, .timer_irq_i, .soft_irq_i, .priv_lvl_i(priv_lvl_o),
    .mstatus_mie_i(mstatus.mie), .mie_o(mie), .mip_o(mip), .irq_pending_o
  );

  csr_counters cnt (
    .clk, .reset, .cmt_we_i(cmt_we), .cmt_addr_i(cmt_addr), .cmt_data_i(cmt_data),
    .commit_count_i, .mcycle_o(mcycle), .minstret_o(minstret)
  );

  // live read port
  csr_read_mux rd_mux (
    .addr_i(rd_addr_i), .mstatus_i(mstatus), .mie_i(mie), .mip_i(mip),
    .mtvec_i(mtvec), .mscratch_i(mscratch), .mepc_i(epc_o), .mcause_i(mcause),
    .mcycle_i(mcycle), .minstret_i(minstret), .hart_id_i, .data_o(rd_data_o)
  );

  // current value of the checkpointed CSR
  csr_read_mux chk_mux (
    .addr_i(chk_addr), .mstatus_i(mstatus), .mie_i(mie), .mip_i(mip),
    .mtvec_i(mtvec), .mscratch_i(mscratch), .mepc_i(epc_o), .mcause_i(mcause),
    .mcycle_i(mcycle), .minstret_i(minstret), .hart_id_i, .data_o(chk_data)
  );

  csr_atomic_check atomic (
    .clk, .reset, .rd_en_i, .flush_i, .commit_i, .rd_addr_i,
    .rd_data_i(rd_data_o), .cur_data_i(chk_data), .chk_addr_o(chk_addr),
    .atomic_vio_o
  );

endmodule

/* csr_atomic_check.sv */
//**************************************************************************
// flags a change of the CSR last read before that instruction commits
//**************************************************************************
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_atomic_check (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   rd_en_i,
  input  logic                   flush_i,
  input  logic                   commit_i,
  input  logic [`CSR_ADDR_W-1:0] rd_addr_i,
  input  logic [`CSR_XLEN-1:0]   rd_data_i,
  input  logic [`CSR_XLEN-1:0]   cur_data_i,
  output logic [`CSR_ADDR_W-1:0] chk_addr_o,
  output logic                   atomic_vio_o
);

  logic                 chk_valid_q;
  logic [`CSR_XLEN-1:0] chk_data_q;

  always_ff @(posedge clk) begin
    if (rd_en_i) begin
      chk_addr_o <= rd_addr_i;
      chk_data_q <= rd_data_i;
    end
  end

  // a new read wins over commit or flush in the same cycle
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      chk_valid_q <= 1'b0;
    end else if (rd_en_i) begin
      chk_valid_q <= 1'b1;
    end else if (flush_i || commit_i) begin
      chk_valid_q <= 1'b0;
    end
  end

  // cur_data_i is the live value at chk_addr_o
  assign atomic_vio_o = chk_valid_q && (cur_data_i != chk_data_q);

endmodule

/* csr_read_mux.sv */
//**************************************************************************
// address decode to the architectural value; unknown addresses give zero
//**************************************************************************
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_read_mux (
  input  logic [`CSR_ADDR_W-1:0] addr_i,
  input  csr_priv_pkg::mstatus_t mstatus_i,
  input  logic [`CSR_XLEN-1:0]   mie_i,
  input  logic [`CSR_XLEN-1:0]   mip_i,
  input  logic [`CSR_XLEN-1:0]   mtvec_i,
  input  logic [`CSR_XLEN-1:0]   mscratch_i,
  input  logic [`CSR_XLEN-1:0]   mepc_i,
  input  logic [`CSR_XLEN-1:0]   mcause_i,
  input  logic [`CSR_XLEN-1:0]   mcycle_i,
  input  logic [`CSR_XLEN-1:0]   minstret_i,
  input  logic [`CSR_XLEN-1:0]   hart_id_i,
  output logic [`CSR_XLEN-1:0]   data_o
);

  logic [`CSR_XLEN-1:0] mstatus_word;

  // place the implemented fields in the 32-bit layout
  always_comb begin
    mstatus_word = '0;
    mstatus_word[csr_priv_pkg::MSTATUS_MIE_BIT]      = mstatus_i.mie;
    mstatus_word[csr_priv_pkg::MSTATUS_MPIE_BIT]     = mstatus_i.mpie;
    mstatus_word[csr_priv_pkg::MSTATUS_MPP_LSB +: 2] = mstatus_i.mpp;
  end

  always_comb begin
    case (addr_i)
      csr_addr_pkg::CSR_MSTATUS:  data_o = mstatus_word;
      csr_addr_pkg::CSR_MISA:     data_o = csr_addr_pkg::MISA_VAL;
      csr_addr_pkg::CSR_MIE:      data_o = mie_i;
      csr_addr_pkg::CSR_MIP:      data_o = mip_i;
      csr_addr_pkg::CSR_MTVEC:    data_o = mtvec_i;
      csr_addr_pkg::CSR_MSCRATCH: data_o = mscratch_i;
      csr_addr_pkg::CSR_MEPC:     data_o = mepc_i;
      csr_addr_pkg::CSR_MCAUSE:   data_o = mcause_i;
      // user counters alias the machine ones
      csr_addr_pkg::CSR_MCYCLE,
      csr_addr_pkg::CSR_CYCLE:    data_o = mcycle_i;
      csr_addr_pkg::CSR_MINSTRET,
      csr_addr_pkg::CSR_INSTRET:  data_o = minstret_i;
      csr_addr_pkg::CSR_MHARTID:  data_o = hart_id_i;
      default:                    data_o = '0;
    endcase
  end

endmodule

/* csr_counters.sv */
//**************************************************************************
// mcycle and minstret; a committed write replaces that cycle's increment
//**************************************************************************
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_counters (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     cmt_we_i,
  input  logic [`CSR_ADDR_W-1:0]   cmt_addr_i,
  input  logic [`CSR_XLEN-1:0]     cmt_data_i,
  input  logic [`CSR_COMMIT_W-1:0] commit_count_i,
  output logic [`CSR_XLEN-1:0]     mcycle_o,
  output logic [`CSR_XLEN-1:0]     minstret_o
);

  logic wr_mcycle;
  logic wr_minstret;

  assign wr_mcycle   = cmt_we_i && (cmt_addr_i == csr_addr_pkg::CSR_MCYCLE);
  assign wr_minstret = cmt_we_i && (cmt_addr_i == csr_addr_pkg::CSR_MINSTRET);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mcycle_o   <= '0;
      minstret_o <= '0;
    end else begin
      mcycle_o   <= wr_mcycle ? cmt_data_i : mcycle_o + 1'b1;
      // commit_count_i is the number retired this cycle
      minstret_o <= wr_minstret ? cmt_data_i :
                    minstret_o + {{(`CSR_XLEN-`CSR_COMMIT_W){1'b0}}, commit_count_i};
    end
  end

endmodule

/* csr_irq_ctrl.sv */
//**************************************************************************
// mie register and mip from level-sensitive lines; mip is not writable
//**************************************************************************
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_irq_ctrl (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    cmt_we_i,
  input  logic [`CSR_ADDR_W-1:0]  cmt_addr_i,
  input  logic [`CSR_XLEN-1:0]    cmt_data_i,
  input  logic                    ext_irq_i,
  input  logic                    timer_irq_i,
  input  logic                    soft_irq_i,
  input  csr_priv_pkg::priv_lvl_e priv_lvl_i,
  input  logic                    mstatus_mie_i,
  output logic [`CSR_XLEN-1:0]    mie_o,
  output logic [`CSR_XLEN-1:0]    mip_o,
  output logic                    irq_pending_o
);

  logic any_enabled;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mie_o <= '0;
    end else if (cmt_we_i && (cmt_addr_i == csr_addr_pkg::CSR_MIE)) begin
      mie_o <= cmt_data_i & csr_priv_pkg::MIE_WRITE_MASK;
    end
  end

  always_comb begin
    mip_o = '0;
    mip_o[csr_priv_pkg::IRQ_M_SOFT]  = soft_irq_i;
    mip_o[csr_priv_pkg::IRQ_M_TIMER] = timer_irq_i;
    mip_o[csr_priv_pkg::IRQ_M_EXT]   = ext_irq_i;
  end

  assign any_enabled = |(mie_o & mip_o);

  // user mode has no global enable, machine traps are always taken there
  always_comb begin
    if (priv_lvl_i == csr_priv_pkg::PRIV_MACHINE) begin
      irq_pending_o = any_enabled & mstatus_mie_i;
    end else begin
      irq_pending_o = any_enabled;
    end
  end

endmodule

/* csr_trap_ctrl.sv */
//**************************************************************************
// privilege and trap CSRs; a committed write beats the trap update of the
// same register, exception beats mret
//**************************************************************************
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_trap_ctrl (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      cmt_we_i,
  input  logic [`CSR_ADDR_W-1:0]    cmt_addr_i,
  input  logic [`CSR_XLEN-1:0]      cmt_data_i,
  input  logic                      exception_i,
  input  logic [`CSR_XLEN-1:0]      exception_pc_i,
  input  csr_priv_pkg::trap_cause_e exception_cause_i,
  input  logic                      mret_i,
  input  logic [`CSR_XLEN-1:0]      start_pc_i,
  output csr_priv_pkg::priv_lvl_e   priv_lvl_o,
  output csr_priv_pkg::mstatus_t    mstatus_o,
  output logic [`CSR_XLEN-1:0]      mepc_o,
  output logic [`CSR_XLEN-1:0]      mcause_o,
  output logic [`CSR_XLEN-1:0]      mtvec_o,
  output logic [`CSR_XLEN-1:0]      mscratch_o,
  output logic [`CSR_XLEN-1:0]      evec_o
);

  logic wr_mstatus;
  logic wr_mepc;
  logic wr_mcause;
  logic wr_mtvec;
  logic wr_mscratch;
  csr_priv_pkg::priv_lvl_e priv_d;
  csr_priv_pkg::mstatus_t  mstatus_d;
  csr_priv_pkg::mstatus_t  mstatus_wr;

  assign wr_mstatus  = cmt_we_i && (cmt_addr_i == csr_addr_pkg::CSR_MSTATUS);
  assign wr_mepc     = cmt_we_i && (cmt_addr_i == csr_addr_pkg::CSR_MEPC);
  assign wr_mcause   = cmt_we_i && (cmt_addr_i == csr_addr_pkg::CSR_MCAUSE);
  assign wr_mtvec    = cmt_we_i && (cmt_addr_i == csr_addr_pkg::CSR_MTVEC);
  assign wr_mscratch = cmt_we_i && (cmt_addr_i == csr_addr_pkg::CSR_MSCRATCH);

  // mpp only holds legal levels, anything but machine becomes user
  always_comb begin
    mstatus_wr.mie  = cmt_data_i[csr_priv_pkg::MSTATUS_MIE_BIT];
    mstatus_wr.mpie = cmt_data_i[csr_priv_pkg::MSTATUS_MPIE_BIT];
    if (cmt_data_i[csr_priv_pkg::MSTATUS_MPP_LSB +: 2] == 2'b11) begin
      mstatus_wr.mpp = csr_priv_pkg::PRIV_MACHINE;
    end else begin
      mstatus_wr.mpp = csr_priv_pkg::PRIV_USER;
    end
  end

  // trap entry stacks mie and privilege, mret pops them
  always_comb begin
    priv_d    = priv_lvl_o;
    mstatus_d = mstatus_o;
    if (exception_i) begin
      mstatus_d.mpie = mstatus_o.mie;
      mstatus_d.mie  = 1'b0;
      mstatus_d.mpp  = priv_lvl_o;
      priv_d         = csr_priv_pkg::PRIV_MACHINE;
    end else if (mret_i) begin
      mstatus_d.mie  = mstatus_o.mpie;
      mstatus_d.mpie = 1'b1;
      mstatus_d.mpp  = csr_priv_pkg::PRIV_USER;
      priv_d         = mstatus_o.mpp;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      priv_lvl_o <= csr_priv_pkg::PRIV_MACHINE;
      mstatus_o  <= '0;
      mepc_o     <= '0;
      mcause_o   <= '0;
      mtvec_o    <= start_pc_i;
      mscratch_o <= '0;
    end else begin
      priv_lvl_o <= priv_d;
      mstatus_o  <= wr_mstatus ? mstatus_wr : mstatus_d;
      if (wr_mepc) begin
        mepc_o <= {cmt_data_i[`CSR_XLEN-1:1], 1'b0};
      end else if (exception_i) begin
        mepc_o <= {exception_pc_i[`CSR_XLEN-1:1], 1'b0};
      end
      if (wr_mcause) begin
        mcause_o <= cmt_data_i;
      end else if (exception_i) begin
        mcause_o <= {{(`CSR_XLEN-`CSR_CAUSE_W){1'b0}}, exception_cause_i};
      end
      // bit 1 of mtvec is reserved in direct and vectored modes
      if (wr_mtvec) begin
        mtvec_o <= {cmt_data_i[`CSR_XLEN-1:2], 1'b0, cmt_data_i[0]};
      end
      if (wr_mscratch) begin
        mscratch_o <= cmt_data_i;
      end
    end
  end

  // trap target is the base field only
  assign evec_o = {mtvec_o[`CSR_XLEN-1:2], 2'b00};

endmodule

/* csr_write_buffer.sv */
//**************************************************************************
// one pending CSR write; commit does not clear it, only flush or a new write
//**************************************************************************
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_write_buffer (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   flush_i,
  input  logic                   wr_en_i,
  input  logic [`CSR_ADDR_W-1:0] wr_addr_i,
  input  logic [`CSR_XLEN-1:0]   wr_data_i,
  input  logic                   commit_i,
  output logic                   cmt_we_o,
  output logic [`CSR_ADDR_W-1:0] cmt_addr_o,
  output logic [`CSR_XLEN-1:0]   cmt_data_o
);

  logic pending_q;

  // a newer write simply replaces the held one
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      cmt_addr_o <= wr_addr_i;
      cmt_data_o <= wr_data_i;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pending_q <= 1'b0;
    end else if (wr_en_i) begin
      pending_q <= 1'b1;
    end else if (flush_i) begin
      pending_q <= 1'b0;
    end
  end

  // becomes architectural in the commit cycle
  assign cmt_we_o = commit_i & pending_q;

endmodule

/* csr_priv_pkg.sv */
//**************************************************************************
// privilege, trap cause and mstatus layout; machine and user mode only
//**************************************************************************
`include "csr_cfg.svh"

package csr_priv_pkg;

  typedef enum logic [1:0] {
    PRIV_USER    = 2'd0,
    PRIV_MACHINE = 2'd3
  } priv_lvl_e;

  typedef enum logic [`CSR_CAUSE_W-1:0] {
    CAUSE_MISALIGNED_FETCH = 5'd0,
    CAUSE_ILLEGAL_INSTR    = 5'd2,
    CAUSE_BREAKPOINT       = 5'd3,
    CAUSE_ECALL_U          = 5'd8,
    CAUSE_ECALL_M          = 5'd11
  } trap_cause_e;

  // implemented mstatus fields, everything else reads as zero
  typedef struct packed {
    priv_lvl_e mpp;
    logic      mpie;
    logic      mie;
  } mstatus_t;

  // field positions in the 32-bit mstatus word
  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;
  localparam int MSTATUS_MPP_LSB  = 11;

  // interrupt bit positions in mie and mip
  localparam int IRQ_M_SOFT  = 3;
  localparam int IRQ_M_TIMER = 7;
  localparam int IRQ_M_EXT   = 11;

  localparam logic [`CSR_XLEN-1:0] MIE_WRITE_MASK = 32'h0000_0888;

endpackage

/* csr_addr_pkg.sv */
//**************************************************************************
// supported CSR addresses; any other address reads as zero
//**************************************************************************
`include "csr_cfg.svh"

package csr_addr_pkg;

  typedef enum logic [`CSR_ADDR_W-1:0] {
    CSR_MSTATUS  = 12'h300,
    CSR_MISA     = 12'h301,
    CSR_MIE      = 12'h304,
    CSR_MTVEC    = 12'h305,
    CSR_MSCRATCH = 12'h340,
    CSR_MEPC     = 12'h341,
    CSR_MCAUSE   = 12'h342,
    CSR_MIP      = 12'h344,
    CSR_MCYCLE   = 12'hB00,
    CSR_MINSTRET = 12'hB02,
    CSR_CYCLE    = 12'hC00,
    CSR_INSTRET  = 12'hC02,
    CSR_MHARTID  = 12'hF14
  } csr_addr_e;

  // MXL = 1 (RV32), I base and U mode
  localparam logic [`CSR_XLEN-1:0] MISA_VAL = 32'h4010_0100;

endpackage

/* csr_cfg.svh */
//**************************************************************************
// widths of the RV32 machine-mode CSR file; only a 32-bit XLEN is supported
//**************************************************************************
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// register and data width
`define CSR_XLEN     32

// address field of a CSR instruction
`define CSR_ADDR_W   12

// instructions retired per cycle, 0 to 7
`define CSR_COMMIT_W 3

// exception cause code, zero-extended into mcause
`define CSR_CAUSE_W  5

`endif
